// ==== dv/lsu_checker.sv ====
`timescale 1ns/1ps

module lsu_checker #(
	parameter int LANES = 2
) (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               issue_valid,
	input  logic               issue_ready,
	input  isa_pkg::mem_op_t   issue_op,
	input  isa_pkg::word_t     issue_base,
	input  isa_pkg::word_t     issue_rt,
	input  isa_pkg::imm_t      issue_imm,
	input  isa_pkg::tag_t      issue_tag,
	input  logic               dbus_req_valid,
	input  logic               dbus_ready,
	input  mem_pkg::paddr_t    dbus_paddr,
	input  mem_pkg::byte_en_t  dbus_be,
	input  logic               wb_valid,
	input  isa_pkg::tag_t      wb_tag,
	input  isa_pkg::word_t     wb_data,
	input  logic               wb_is_store,
	input  mem_pkg::paddr_t    wb_paddr,
	input  mem_pkg::byte_en_t  wb_be,
	input  isa_pkg::word_t     wb_wrdata,
	input  logic               wb_exc_valid,
	input  isa_pkg::exc_code_t wb_exc_code,
	input  mem_pkg::vaddr_t    wb_badvaddr,
	input  isa_pkg::word_t     mem [64],
	output int                 value_errs,
	output int                 tag_errs,
	output int                 reads_seen,
	output int                 reads_expected
);

isa_pkg::mem_op_t t_op [16];
isa_pkg::word_t t_base [16];
isa_pkg::word_t t_rt [16];
isa_pkg::imm_t t_imm [16];
logic [15:0] live;

// bus reads in the order they were accepted
mem_pkg::paddr_t bus_paddr_q [$];
mem_pkg::byte_en_t bus_be_q [$];

// expected writeback from the MIPS rules with little-endian byte lanes
function automatic void predict(input isa_pkg::mem_op_t op, input isa_pkg::word_t base,
		input isa_pkg::word_t rt, input isa_pkg::imm_t imm, input isa_pkg::word_t mw,
		output isa_pkg::word_t data, output logic st, output mem_pkg::paddr_t pa,
		output mem_pkg::byte_en_t be, output isa_pkg::word_t wr, output logic ev,
		output isa_pkg::exc_code_t ec, output mem_pkg::vaddr_t va);
	logic [1:0] off;
	logic misal;
	logic mapped;
	int k;
	va     = base + {{16{imm[15]}}, imm};
	off    = va[1:0];
	pa     = {3'b000, va[28:0]};
	st     = isa_pkg::is_store(op);
	mapped = (va >= mem_pkg::KSEG0_BASE) && (va < mem_pkg::KSEG2_BASE);
	misal  = 1'b0;
	data   = '0;
	wr     = '0;
	be     = '0;
	case (op)
		isa_pkg::OP_LW, isa_pkg::OP_SW: begin
			be    = 4'hF;
			misal = (off != 0);
		end
		isa_pkg::OP_LH, isa_pkg::OP_LHU, isa_pkg::OP_SH: begin
			be    = off[1] ? 4'hC : 4'h3;
			misal = off[0];
		end
		default: ;
	endcase
	for (int i = 0; i < 4; i++) begin
		case (op)
			isa_pkg::OP_LB, isa_pkg::OP_LBU, isa_pkg::OP_SB: be[i] = (i == off);
			isa_pkg::OP_LWL: be[i] = (i >= 3 - off);
			isa_pkg::OP_LWR: be[i] = (i <= 3 - off);
			isa_pkg::OP_SWL: be[i] = (i <= off);
			isa_pkg::OP_SWR: be[i] = (i >= off);
			default: ;
		endcase
	end
	// store data moves up by k bytes and swl moves down
	k = 0;
	if (op == isa_pkg::OP_SH)
		k = off[1] ? 2 : 0;
	else if (op == isa_pkg::OP_SB || op == isa_pkg::OP_SWR)
		k = off;
	else if (op == isa_pkg::OP_SWL)
		k = off - 3;
	if (st)
		for (int i = 0; i < 4; i++)
			if (i - k >= 0 && i - k < 4)
				wr[8*i +: 8] = rt[8*(i-k) +: 8];
	ev = misal || !mapped;
	if (misal)
		ec = st ? isa_pkg::EXC_ADES : isa_pkg::EXC_ADEL;
	else if (!mapped)
		ec = st ? isa_pkg::EXC_TLBS : isa_pkg::EXC_TLBL;
	else
		ec = '0;
	if (!st && !ev) begin
		case (op)
			isa_pkg::OP_LB:  data = {{24{mw[8*off+7]}}, mw[8*off +: 8]};
			isa_pkg::OP_LBU: data = {24'h0, mw[8*off +: 8]};
			isa_pkg::OP_LH:  data = {{16{mw[16*off[1]+15]}}, mw[16*off[1] +: 16]};
			isa_pkg::OP_LHU: data = {16'h0, mw[16*off[1] +: 16]};
			isa_pkg::OP_LWL, isa_pkg::OP_LWR: begin
				data = rt;
				for (int i = 0; i < 4; i++)
					if (be[i])
						data[8*i +: 8] = (op == isa_pkg::OP_LWL) ?
							mw[8*(i-3+off) +: 8] : mw[8*(i+off) +: 8];
			end
			default: data = mw;
		endcase
	end
endfunction

task automatic check_field(input string name, input isa_pkg::tag_t tag,
		input logic [31:0] got, input logic [31:0] exp);
	if (got !== exp) begin
		$display("ERROR %0t: tag %0d %s is %h, expected %h", $time, tag, name, got, exp);
		value_errs++;
	end
endtask

initial begin
	value_errs     = 0;
	tag_errs       = 0;
	reads_seen     = 0;
	reads_expected = 0;
	live           = '0;
end

// everything sampled mid-cycle where the DUT outputs are settled
always @(negedge clk) begin
	isa_pkg::word_t d;
	isa_pkg::word_t w;
	logic s;
	logic ev;
	mem_pkg::paddr_t pa;
	mem_pkg::vaddr_t va;
	mem_pkg::byte_en_t be;
	isa_pkg::exc_code_t ec;
	int in_flight;
	if (arst_n) begin
		if (dbus_req_valid && dbus_ready) begin
			reads_seen++;
			bus_paddr_q.push_back(dbus_paddr);
			bus_be_q.push_back(dbus_be);
		end
		if (issue_valid && issue_ready) begin
			// ops still held in a lane or in the dispatcher
			in_flight = $countones(live);
			if (wb_valid && live[wb_tag])
				in_flight--;
			if (in_flight >= LANES) begin
				$display("ERROR %0t: tag %0d accepted with %0d ops in flight", $time,
					issue_tag, in_flight);
				value_errs++;
			end
			if (live[issue_tag]) begin
				$display("tag %0d issued again while still in flight", issue_tag);
				tag_errs++;
			end
			live[issue_tag]  = 1'b1;
			t_op[issue_tag]   = issue_op;
			t_base[issue_tag] = issue_base;
			t_rt[issue_tag]   = issue_rt;
			t_imm[issue_tag]  = issue_imm;
		end
		if (wb_valid) begin
			if (!live[wb_tag]) begin
				$display("writeback for tag %0d, which is not in flight", wb_tag);
				tag_errs++;
			end else begin
				va = t_base[wb_tag] + {{16{t_imm[wb_tag][15]}}, t_imm[wb_tag]};
				predict(t_op[wb_tag], t_base[wb_tag], t_rt[wb_tag], t_imm[wb_tag],
					mem[va[7:2]], d, s, pa, be, w, ev, ec, va);
				if (!s && !ev) begin
					reads_expected++;
					if (bus_paddr_q.size() == 0) begin
						$display("load tag %0d written back with no bus read", wb_tag);
						value_errs++;
					end else begin
						check_field("bus paddr", wb_tag, bus_paddr_q.pop_front(), pa);
						check_field("bus be", wb_tag, bus_be_q.pop_front(), be);
					end
				end
				check_field("data", wb_tag, wb_data, d);
				check_field("is_store", wb_tag, wb_is_store, s);
				check_field("paddr", wb_tag, wb_paddr, pa);
				check_field("be", wb_tag, wb_be, be);
				check_field("wrdata", wb_tag, wb_wrdata, w);
				check_field("exc_valid", wb_tag, wb_exc_valid, ev);
				check_field("exc_code", wb_tag, wb_exc_code, ec);
				check_field("badvaddr", wb_tag, wb_badvaddr, va);
				live[wb_tag] = 1'b0;
			end
		end
	end
end

endmodule

// ==== dv/lsu_cluster_asserts.sv ====
`timescale 1ns/1ps

module lsu_cluster_asserts #(
	parameter int LANES = 2
) (
	input logic               clk,
	input logic               arst_n,
	input logic               dbus_req_valid,
	input mem_pkg::paddr_t    dbus_paddr,
	input logic               dbus_ready,
	input logic               dbus_rdata_valid,
	input logic [LANES-1:0]   lane_grant,
	input logic               wb_valid
);

logic outstanding;

// read accepted but not yet answered
always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n)
		outstanding <= 1'b0;
	else if (dbus_req_valid && dbus_ready)
		outstanding <= 1'b1;
	else if (dbus_rdata_valid)
		outstanding <= 1'b0;
end

req_held: assert property (@(posedge clk) disable iff (!arst_n)
	dbus_req_valid && !dbus_ready |=> dbus_req_valid && $stable(dbus_paddr))
	else $error("bus request dropped or changed before dbus_ready");

one_read: assert property (@(posedge clk) disable iff (!arst_n)
	!(outstanding && dbus_req_valid))
	else $error("second bus request while a read is outstanding");

one_grant: assert property (@(posedge clk) disable iff (!arst_n)
	$onehot0(lane_grant))
	else $error("more than one lane_grant high");

wb_known: assert property (@(posedge clk) disable iff (!arst_n)
	!$isunknown(wb_valid))
	else $error("wb_valid is unknown");

endmodule

// ==== dv/lsu_cluster_tb.sv ====
`timescale 1ns/1ps

module lsu_cluster_tb;

localparam int LANES     = 2;
localparam int NUM_OPS   = 200;
localparam int MAX_CYCLE = NUM_OPS * 20 + 10;

logic clk;
logic arst_n;
logic issue_valid;
logic issue_ready;
isa_pkg::mem_op_t issue_op;
isa_pkg::word_t issue_base;
isa_pkg::word_t issue_rt;
isa_pkg::imm_t issue_imm;
isa_pkg::tag_t issue_tag;
logic dbus_req_valid;
mem_pkg::paddr_t dbus_paddr;
mem_pkg::byte_en_t dbus_be;
logic dbus_ready;
logic dbus_rdata_valid;
isa_pkg::word_t dbus_rdata;
logic wb_valid;
isa_pkg::tag_t wb_tag;
isa_pkg::word_t wb_data;
logic wb_is_store;
mem_pkg::paddr_t wb_paddr;
mem_pkg::byte_en_t wb_be;
isa_pkg::word_t wb_wrdata;
logic wb_exc_valid;
isa_pkg::exc_code_t wb_exc_code;
mem_pkg::vaddr_t wb_badvaddr;

isa_pkg::word_t mem [64];
logic [31:0] stim_lfsr;
logic [31:0] bus_lfsr;
logic [15:0] busy_tags;
int value_errs;
int tag_errs;
int reads_seen;
int reads_expected;
int cycles;
int resp_wait;
logic [5:0] resp_idx;

tb_clock clock_i (
	.clk    (clk),
	.arst_n (arst_n)
);

lsu_cluster #(
	.LANES (LANES)
) dut_i (.*);

lsu_checker #(
	.LANES (LANES)
) checker_i (.*);

bind lsu_cluster lsu_cluster_asserts #(.LANES(LANES)) asserts_i (
	.clk              (clk),
	.arst_n           (arst_n),
	.dbus_req_valid   (dbus_req_valid),
	.dbus_paddr       (dbus_paddr),
	.dbus_ready       (dbus_ready),
	.dbus_rdata_valid (dbus_rdata_valid),
	.lane_grant       (lane_grant),
	.wb_valid         (wb_valid)
);

function automatic logic [31:0] lfsr_next(logic [31:0] s);
	return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

task automatic take_bits(inout logic [31:0] st, input int n, output logic [31:0] v);
	v = '0;
	for (int i = 0; i < n; i++) begin
		v[i] = st[0];
		st   = lfsr_next(st);
	end
endtask

// read-only memory model with random ready and a 1 to 4 cycle response
always @(negedge clk) begin
	logic [31:0] r;
	if (arst_n && dbus_req_valid && dbus_ready) begin
		take_bits(bus_lfsr, 2, r);
		resp_idx  = dbus_paddr[7:2];
		resp_wait = r + 1;
	end
	if (wb_valid)
		busy_tags[wb_tag] = 1'b0;
end

always @(posedge clk) begin
	logic [31:0] r;
	#1;
	dbus_rdata_valid = 1'b0;
	if (resp_wait > 0) begin
		resp_wait--;
		if (resp_wait == 0) begin
			dbus_rdata_valid = 1'b1;
			dbus_rdata       = mem[resp_idx];
		end
	end
	take_bits(bus_lfsr, 1, r);
	dbus_ready = r[0];
end

always @(posedge clk) begin
	cycles++;
	if (cycles > MAX_CYCLE) begin
		$display("timeout: run did not finish within %0d cycles", MAX_CYCLE);
		$display("Test failed");
		$finish;
	end
end

initial begin
	logic [31:0] r;
	logic [31:0] seg;
	logic acc;
	stim_lfsr        = 32'd36;
	bus_lfsr         = 32'd36;
	busy_tags        = '0;
	cycles           = 0;
	resp_wait        = 0;
	resp_idx         = '0;
	issue_valid      = 1'b0;
	issue_op         = isa_pkg::OP_LW;
	issue_base       = '0;
	issue_rt         = '0;
	issue_imm        = '0;
	issue_tag        = '0;
	dbus_ready       = 1'b0;
	dbus_rdata_valid = 1'b0;
	dbus_rdata       = '0;
	for (int i = 0; i < 64; i++) begin
		take_bits(stim_lfsr, 32, r);
		mem[i] = r;
	end
	@(posedge arst_n);
	@(posedge clk);
	#1;
	for (int n = 0; n < NUM_OPS; n++) begin
		while (busy_tags[n % 16]) begin
			@(posedge clk);
			#1;
		end
		issue_tag = n % 16;
		take_bits(stim_lfsr, 4, r);
		issue_op = isa_pkg::mem_op_t'(r % 12);
		take_bits(stim_lfsr, 3, r);
		// mostly kseg0 and kseg1 with kuseg now and then
		if (r == 7)
			seg = 32'h0040_0000;
		else if (r >= 3 && r <= 5)
			seg = mem_pkg::KSEG1_BASE;
		else
			seg = mem_pkg::KSEG0_BASE;
		take_bits(stim_lfsr, 6, r);
		issue_base = seg + 32'h100 + {r[5:0], 2'b00};
		take_bits(stim_lfsr, 6, r);
		issue_imm = {{10{r[5]}}, r[5:0]};
		take_bits(stim_lfsr, 2, r);
		if (r != 0) begin
			if (issue_op inside {isa_pkg::OP_LW, isa_pkg::OP_SW})
				issue_imm[1:0] = 2'b00;
			if (issue_op inside {isa_pkg::OP_LH, isa_pkg::OP_LHU, isa_pkg::OP_SH})
				issue_imm[0] = 1'b0;
		end
		take_bits(stim_lfsr, 32, r);
		issue_rt    = r;
		issue_valid = 1'b1;
		do begin
			@(negedge clk);
			acc = issue_ready;
			if (acc)
				busy_tags[issue_tag] = 1'b1;
			@(posedge clk);
			#1;
		end while (!acc);
		issue_valid = 1'b0;
	end
	while (busy_tags != 0)
		@(negedge clk);
	repeat (4) @(posedge clk);
	if (reads_seen != reads_expected)
		$display("bus reads seen %0d, but %0d loads needed a read", reads_seen,
			reads_expected);
	$display("errors: %0d value, %0d tag, bus reads %0d of %0d expected", value_errs,
		tag_errs, reads_seen, reads_expected);
	if (value_errs == 0 && tag_errs == 0 && reads_seen == reads_expected)
		$display("Test passed");
	else
		$display("Test failed");
	$finish;
end

endmodule

// ==== dv/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic arst_n
);

initial begin
	clk    = 1'b0;
	arst_n = 1'b0;
	forever #20 clk = ~clk;
end

// hold reset for ten rising edges
initial begin
	repeat (10) @(posedge clk);
	#1 arst_n = 1'b1;
end

endmodule

// ==== project.f ====
rtl/isa_pkg.sv
rtl/mem_pkg.sv
rtl/lsu_dispatch.sv
rtl/seg_map.sv
rtl/lsu.sv
rtl/dbus_arbiter.sv
rtl/lsu_writeback.sv
rtl/lsu_cluster.sv
dv/tb_clock.sv
dv/lsu_cluster_asserts.sv
dv/lsu_checker.sv
dv/lsu_cluster_tb.sv

// ==== rtl/dbus_arbiter.sv ====
`timescale 1ns/1ps

module dbus_arbiter #(
	parameter int LANES = 2
) (
	input  logic                                clk,
	input  logic                                arst_n,
	input  logic [LANES-1:0]                    rd_req,
	input  mem_pkg::paddr_t [LANES-1:0]         rd_paddr,
	input  mem_pkg::byte_en_t [LANES-1:0]       rd_be,
	input  logic                                dbus_ready,
	input  logic                                dbus_rdata_valid,
	input  isa_pkg::word_t                      dbus_rdata,
	output logic [LANES-1:0]                    rd_data_valid,
	output isa_pkg::word_t                      rd_data,
	output logic                                dbus_req_valid,
	output mem_pkg::paddr_t                     dbus_paddr,
	output mem_pkg::byte_en_t                   dbus_be
);

localparam int IW = (LANES > 1) ? $clog2(LANES) : 1;

typedef enum logic [1:0] {
	ARB_IDLE,
	ARB_REQ,
	ARB_RESP
} arb_state_t;

arb_state_t state;
logic [IW-1:0] owner;
logic [IW-1:0] lowest;

always_comb begin
	lowest = '0;
	for (int i = LANES - 1; i >= 0; i--)
		if (rd_req[i])
			lowest = IW'(i);
end

// one read in flight, owner fixed until the response
always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		state <= ARB_IDLE;
		owner <= '0;
	end else begin
		unique case (state)
			ARB_IDLE:
				if (|rd_req) begin
					owner <= lowest;
					state <= ARB_REQ;
				end
			ARB_REQ:
				if (dbus_ready)
					state <= ARB_RESP;
			ARB_RESP:
				if (dbus_rdata_valid)
					state <= ARB_IDLE;
			default:
				state <= ARB_IDLE;
		endcase
	end
end

assign dbus_req_valid = (state == ARB_REQ);
assign dbus_paddr     = rd_paddr[owner];
assign dbus_be        = rd_be[owner];
assign rd_data        = dbus_rdata;

always_comb begin
	rd_data_valid = '0;
	if (state == ARB_RESP && dbus_rdata_valid)
		rd_data_valid[owner] = 1'b1;
end

endmodule

// ==== rtl/isa_pkg.sv ====
package isa_pkg;

typedef logic [31:0] word_t;
typedef logic [15:0] imm_t;
typedef logic [3:0]  tag_t;
typedef logic [4:0]  exc_code_t;

typedef enum logic [3:0] {
	OP_LW,
	OP_LH,
	OP_LHU,
	OP_LB,
	OP_LBU,
	OP_LWL,
	OP_LWR,
	OP_SW,
	OP_SH,
	OP_SB,
	OP_SWL,
	OP_SWR
} mem_op_t;

typedef enum logic {
	FU_LOAD,
	FU_STORE
} fu_t;

// cp0 cause codes
localparam exc_code_t EXC_TLBL = 5'd2;
localparam exc_code_t EXC_TLBS = 5'd3;
localparam exc_code_t EXC_ADEL = 5'd4;
localparam exc_code_t EXC_ADES = 5'd5;

function automatic fu_t fu_kind(mem_op_t op);
	case (op)
		OP_SW, OP_SH, OP_SB, OP_SWL, OP_SWR: return FU_STORE;
		default: return FU_LOAD;
	endcase
endfunction

function automatic logic is_store(mem_op_t op);
	return fu_kind(op) == FU_STORE;
endfunction

endpackage

// ==== rtl/lsu.sv ====
`timescale 1ns/1ps

module lsu (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               start,
	input  isa_pkg::mem_op_t   op,
	input  isa_pkg::word_t     base,
	input  isa_pkg::word_t     rt,
	input  isa_pkg::imm_t      imm,
	input  isa_pkg::tag_t      tag,
	input  logic               rd_data_valid,
	input  isa_pkg::word_t     rd_data,
	input  logic               grant,
	output logic               busy,
	output logic               rd_req,
	output mem_pkg::paddr_t    rd_paddr,
	output mem_pkg::byte_en_t  rd_be,
	output logic               done,
	output isa_pkg::tag_t      res_tag,
	output isa_pkg::word_t     res_data,
	output logic               res_is_store,
	output mem_pkg::paddr_t    res_paddr,
	output mem_pkg::byte_en_t  res_be,
	output isa_pkg::word_t     res_wrdata,
	output logic               res_exc_valid,
	output isa_pkg::exc_code_t res_exc_code,
	output mem_pkg::vaddr_t    res_badvaddr
);

typedef enum logic [1:0] {
	IDLE,
	WAIT_MAP,
	WAIT_DATA,
	DONE
} state_t;

state_t state, state_d;

isa_pkg::mem_op_t op_q;
isa_pkg::word_t base_q;
isa_pkg::word_t rt_q;
isa_pkg::imm_t imm_q;
isa_pkg::tag_t tag_q;

mem_pkg::vaddr_t vaddr;
logic [1:0] off;
logic store;
logic map_request;
logic map_ready;
logic map_miss;
mem_pkg::paddr_t map_paddr;

mem_pkg::byte_en_t be;
isa_pkg::word_t wrdata;
logic unaligned;
logic exc;
isa_pkg::exc_code_t exc_code;

isa_pkg::word_t rd_shr;
isa_pkg::word_t rd_shl;
isa_pkg::word_t mask;
isa_pkg::word_t load_data;

always_ff @(posedge clk) begin
	if (start) begin
		op_q   <= op;
		base_q <= base;
		rt_q   <= rt;
		imm_q  <= imm;
		tag_q  <= tag;
	end
end

assign vaddr = base_q + {{16{imm_q[15]}}, imm_q};
assign off   = vaddr[1:0];
assign store = isa_pkg::is_store(op_q);

assign map_request = (state == WAIT_MAP) & ~map_ready;

seg_map seg_map_i (
	.clk      (clk),
	.arst_n   (arst_n),
	.request  (map_request),
	.vaddr    (vaddr),
	.ready    (map_ready),
	.paddr    (map_paddr),
	.uncached (),
	.miss     (map_miss)
);

// byte lanes and store data shift
always_comb begin
	be        = mem_pkg::BE_ALL;
	wrdata    = '0;
	unaligned = 1'b0;
	unique case (op_q)
		isa_pkg::OP_LW:
			unaligned = |off;
		isa_pkg::OP_SW: begin
			wrdata    = rt_q;
			unaligned = |off;
		end
		isa_pkg::OP_LH, isa_pkg::OP_LHU: begin
			be        = off[1] ? 4'b1100 : 4'b0011;
			unaligned = off[0];
		end
		isa_pkg::OP_SH: begin
			be        = off[1] ? 4'b1100 : 4'b0011;
			wrdata    = rt_q << {off[1], 4'b0000};
			unaligned = off[0];
		end
		isa_pkg::OP_LB, isa_pkg::OP_LBU:
			be = 4'b0001 << off;
		isa_pkg::OP_SB: begin
			be     = 4'b0001 << off;
			wrdata = rt_q << {off, 3'b000};
		end
		isa_pkg::OP_LWL:
			be = mem_pkg::BE_ALL << ~off;
		isa_pkg::OP_LWR:
			be = mem_pkg::BE_ALL >> off;
		isa_pkg::OP_SWL: begin
			be     = mem_pkg::BE_ALL >> ~off;
			wrdata = rt_q >> {~off, 3'b000};
		end
		isa_pkg::OP_SWR: begin
			be     = mem_pkg::BE_ALL << off;
			wrdata = rt_q << {off, 3'b000};
		end
		default: ;
	endcase
end

// address error takes priority over the miss
assign exc = unaligned | map_miss;
always_comb begin
	if (unaligned)
		exc_code = store ? isa_pkg::EXC_ADES : isa_pkg::EXC_ADEL;
	else
		exc_code = store ? isa_pkg::EXC_TLBS : isa_pkg::EXC_TLBL;
end

// load formatting, be doubles as the merge mask for lwl/lwr
assign rd_shr = rd_data >> {off, 3'b000};
assign rd_shl = rd_data << {~off, 3'b000};
assign mask   = {{8{res_be[3]}}, {8{res_be[2]}}, {8{res_be[1]}}, {8{res_be[0]}}};

always_comb begin
	unique case (op_q)
		isa_pkg::OP_LB:  load_data = {{24{rd_shr[7]}}, rd_shr[7:0]};
		isa_pkg::OP_LBU: load_data = {24'b0, rd_shr[7:0]};
		isa_pkg::OP_LH:  load_data = {{16{rd_shr[15]}}, rd_shr[15:0]};
		isa_pkg::OP_LHU: load_data = {16'b0, rd_shr[15:0]};
		isa_pkg::OP_LWL: load_data = (rt_q & ~mask) | (rd_shl & mask);
		isa_pkg::OP_LWR: load_data = (rt_q & ~mask) | (rd_shr & mask);
		default:         load_data = rd_data;
	endcase
end

always_ff @(posedge clk) begin
	if (state == WAIT_MAP && map_ready) begin
		res_paddr     <= map_paddr;
		res_be        <= be;
		res_wrdata    <= wrdata;
		res_is_store  <= store;
		res_exc_valid <= exc;
		res_exc_code  <= exc ? exc_code : '0;
		res_badvaddr  <= vaddr;
		res_data      <= '0;
	end else if (state == WAIT_DATA && rd_data_valid) begin
		res_data <= load_data;
	end
end

always_comb begin
	state_d = state;
	unique case (state)
		IDLE:
			if (start)
				state_d = WAIT_MAP;
		WAIT_MAP:
			if (map_ready)
				state_d = (exc || store) ? DONE : WAIT_DATA;
		WAIT_DATA:
			if (rd_data_valid)
				state_d = DONE;
		DONE:
			if (grant)
				state_d = IDLE;
		default:
			state_d = IDLE;
	endcase
end

always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n)
		state <= IDLE;
	else
		state <= state_d;
end

assign busy     = (state != IDLE);
assign done     = (state == DONE);
assign rd_req   = (state == WAIT_DATA);
assign rd_paddr = res_paddr;
assign rd_be    = res_be;
assign res_tag  = tag_q;

endmodule

// ==== rtl/lsu_cluster.sv ====
`timescale 1ns/1ps

module lsu_cluster #(
	parameter int LANES = 2
) (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               issue_valid,
	input  isa_pkg::mem_op_t   issue_op,
	input  isa_pkg::word_t     issue_base,
	input  isa_pkg::word_t     issue_rt,
	input  isa_pkg::imm_t      issue_imm,
	input  isa_pkg::tag_t      issue_tag,
	output logic               issue_ready,
	output logic               dbus_req_valid,
	output mem_pkg::paddr_t    dbus_paddr,
	output mem_pkg::byte_en_t  dbus_be,
	input  logic               dbus_ready,
	input  logic               dbus_rdata_valid,
	input  isa_pkg::word_t     dbus_rdata,
	output logic               wb_valid,
	output isa_pkg::tag_t      wb_tag,
	output isa_pkg::word_t     wb_data,
	output logic               wb_is_store,
	output mem_pkg::paddr_t    wb_paddr,
	output mem_pkg::byte_en_t  wb_be,
	output isa_pkg::word_t     wb_wrdata,
	output logic               wb_exc_valid,
	output isa_pkg::exc_code_t wb_exc_code,
	output mem_pkg::vaddr_t    wb_badvaddr
);

// shared payload from the dispatcher
isa_pkg::mem_op_t d_op;
isa_pkg::word_t d_base;
isa_pkg::word_t d_rt;
isa_pkg::imm_t d_imm;
isa_pkg::tag_t d_tag;

logic [LANES-1:0] lane_start;
logic [LANES-1:0] lane_busy;
logic [LANES-1:0] rd_req;
mem_pkg::paddr_t [LANES-1:0] rd_paddr;
mem_pkg::byte_en_t [LANES-1:0] rd_be;
logic [LANES-1:0] rd_data_valid;
isa_pkg::word_t rd_data;

logic [LANES-1:0] lane_done;
logic [LANES-1:0] lane_grant;
isa_pkg::tag_t [LANES-1:0] lane_tag;
isa_pkg::word_t [LANES-1:0] lane_data;
logic [LANES-1:0] lane_is_store;
mem_pkg::paddr_t [LANES-1:0] lane_paddr;
mem_pkg::byte_en_t [LANES-1:0] lane_be;
isa_pkg::word_t [LANES-1:0] lane_wrdata;
logic [LANES-1:0] lane_exc_valid;
isa_pkg::exc_code_t [LANES-1:0] lane_exc_code;
mem_pkg::vaddr_t [LANES-1:0] lane_badvaddr;

lsu_dispatch #(
	.LANES (LANES)
) dispatch_i (
	.clk         (clk),
	.arst_n      (arst_n),
	.issue_valid (issue_valid),
	.issue_op    (issue_op),
	.issue_base  (issue_base),
	.issue_rt    (issue_rt),
	.issue_imm   (issue_imm),
	.issue_tag   (issue_tag),
	.lane_busy   (lane_busy),
	.issue_ready (issue_ready),
	.lane_start  (lane_start),
	.op          (d_op),
	.base        (d_base),
	.rt          (d_rt),
	.imm         (d_imm),
	.tag         (d_tag)
);

for (genvar i = 0; i < LANES; i++) begin : g_lane
	lsu lsu_i (
		.clk           (clk),
		.arst_n        (arst_n),
		.start         (lane_start[i]),
		.op            (d_op),
		.base          (d_base),
		.rt            (d_rt),
		.imm           (d_imm),
		.tag           (d_tag),
		.rd_data_valid (rd_data_valid[i]),
		.rd_data       (rd_data),
		.grant         (lane_grant[i]),
		.busy          (lane_busy[i]),
		.rd_req        (rd_req[i]),
		.rd_paddr      (rd_paddr[i]),
		.rd_be         (rd_be[i]),
		.done          (lane_done[i]),
		.res_tag       (lane_tag[i]),
		.res_data      (lane_data[i]),
		.res_is_store  (lane_is_store[i]),
		.res_paddr     (lane_paddr[i]),
		.res_be        (lane_be[i]),
		.res_wrdata    (lane_wrdata[i]),
		.res_exc_valid (lane_exc_valid[i]),
		.res_exc_code  (lane_exc_code[i]),
		.res_badvaddr  (lane_badvaddr[i])
	);
end

dbus_arbiter #(
	.LANES (LANES)
) arbiter_i (
	.clk              (clk),
	.arst_n           (arst_n),
	.rd_req           (rd_req),
	.rd_paddr         (rd_paddr),
	.rd_be            (rd_be),
	.dbus_ready       (dbus_ready),
	.dbus_rdata_valid (dbus_rdata_valid),
	.dbus_rdata       (dbus_rdata),
	.rd_data_valid    (rd_data_valid),
	.rd_data          (rd_data),
	.dbus_req_valid   (dbus_req_valid),
	.dbus_paddr       (dbus_paddr),
	.dbus_be          (dbus_be)
);

lsu_writeback #(
	.LANES (LANES)
) writeback_i (
	.clk            (clk),
	.arst_n         (arst_n),
	.lane_done      (lane_done),
	.lane_tag       (lane_tag),
	.lane_data      (lane_data),
	.lane_is_store  (lane_is_store),
	.lane_paddr     (lane_paddr),
	.lane_be        (lane_be),
	.lane_wrdata    (lane_wrdata),
	.lane_exc_valid (lane_exc_valid),
	.lane_exc_code  (lane_exc_code),
	.lane_badvaddr  (lane_badvaddr),
	.lane_grant     (lane_grant),
	.wb_valid       (wb_valid),
	.wb_tag         (wb_tag),
	.wb_data        (wb_data),
	.wb_is_store    (wb_is_store),
	.wb_paddr       (wb_paddr),
	.wb_be          (wb_be),
	.wb_wrdata      (wb_wrdata),
	.wb_exc_valid   (wb_exc_valid),
	.wb_exc_code    (wb_exc_code),
	.wb_badvaddr    (wb_badvaddr)
);

endmodule

// ==== rtl/lsu_dispatch.sv ====
`timescale 1ns/1ps

module lsu_dispatch #(
	parameter int LANES = 2
) (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   issue_valid,
	input  isa_pkg::mem_op_t       issue_op,
	input  isa_pkg::word_t         issue_base,
	input  isa_pkg::word_t         issue_rt,
	input  isa_pkg::imm_t          issue_imm,
	input  isa_pkg::tag_t          issue_tag,
	input  logic [LANES-1:0]       lane_busy,
	output logic                   issue_ready,
	output logic [LANES-1:0]       lane_start,
	output isa_pkg::mem_op_t       op,
	output isa_pkg::word_t         base,
	output isa_pkg::word_t         rt,
	output isa_pkg::imm_t          imm,
	output isa_pkg::tag_t          tag
);

logic [LANES-1:0] free;
logic [LANES-1:0] pick;
logic pending;
logic ready_en;
logic launch;
logic accept;

assign free = ~lane_busy;

// lowest free lane wins
always_comb begin
	pick = '0;
	for (int i = LANES - 1; i >= 0; i--)
		if (free[i])
			pick = LANES'(1) << i;
end

assign lane_start = pending ? pick : '0;
assign launch     = |lane_start;

// a lane started this cycle counts as taken
assign issue_ready = ready_en & (~pending | launch) & |(free & ~lane_start);
assign accept      = issue_valid & issue_ready;

always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		pending  <= 1'b0;
		ready_en <= 1'b0;
	end else begin
		pending  <= accept | (pending & ~launch);
		ready_en <= 1'b1;
	end
end

always_ff @(posedge clk) begin
	if (accept) begin
		op   <= issue_op;
		base <= issue_base;
		rt   <= issue_rt;
		imm  <= issue_imm;
		tag  <= issue_tag;
	end
end

endmodule

// ==== rtl/lsu_writeback.sv ====
`timescale 1ns/1ps

module lsu_writeback #(
	parameter int LANES = 2
) (
	input  logic                                 clk,
	input  logic                                 arst_n,
	input  logic [LANES-1:0]                     lane_done,
	input  isa_pkg::tag_t [LANES-1:0]            lane_tag,
	input  isa_pkg::word_t [LANES-1:0]           lane_data,
	input  logic [LANES-1:0]                     lane_is_store,
	input  mem_pkg::paddr_t [LANES-1:0]          lane_paddr,
	input  mem_pkg::byte_en_t [LANES-1:0]        lane_be,
	input  isa_pkg::word_t [LANES-1:0]           lane_wrdata,
	input  logic [LANES-1:0]                     lane_exc_valid,
	input  isa_pkg::exc_code_t [LANES-1:0]       lane_exc_code,
	input  mem_pkg::vaddr_t [LANES-1:0]          lane_badvaddr,
	output logic [LANES-1:0]                     lane_grant,
	output logic                                 wb_valid,
	output isa_pkg::tag_t                        wb_tag,
	output isa_pkg::word_t                       wb_data,
	output logic                                 wb_is_store,
	output mem_pkg::paddr_t                      wb_paddr,
	output mem_pkg::byte_en_t                    wb_be,
	output isa_pkg::word_t                       wb_wrdata,
	output logic                                 wb_exc_valid,
	output isa_pkg::exc_code_t                   wb_exc_code,
	output mem_pkg::vaddr_t                      wb_badvaddr
);

localparam int IW = (LANES > 1) ? $clog2(LANES) : 1;

logic [IW-1:0] sel;
logic any_done;

assign any_done = |lane_done;

// fixed priority, losers keep their result held
always_comb begin
	sel = '0;
	for (int i = LANES - 1; i >= 0; i--)
		if (lane_done[i])
			sel = IW'(i);
end

always_comb begin
	lane_grant = '0;
	if (any_done)
		lane_grant[sel] = 1'b1;
end

always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n)
		wb_valid <= 1'b0;
	else
		wb_valid <= any_done;
end

always_ff @(posedge clk) begin
	if (any_done) begin
		wb_tag       <= lane_tag[sel];
		wb_data      <= lane_data[sel];
		wb_is_store  <= lane_is_store[sel];
		wb_paddr     <= lane_paddr[sel];
		wb_be        <= lane_be[sel];
		wb_wrdata    <= lane_wrdata[sel];
		wb_exc_valid <= lane_exc_valid[sel];
		wb_exc_code  <= lane_exc_code[sel];
		wb_badvaddr  <= lane_badvaddr[sel];
	end
end

endmodule

// ==== rtl/mem_pkg.sv ====
package mem_pkg;

typedef logic [31:0] vaddr_t;
typedef logic [31:0] paddr_t;
typedef logic [3:0]  byte_en_t;

localparam byte_en_t BE_ALL = 4'b1111;

// unmapped kernel segments
localparam vaddr_t KSEG0_BASE = 32'h8000_0000;
localparam vaddr_t KSEG1_BASE = 32'hA000_0000;
localparam vaddr_t KSEG2_BASE = 32'hC000_0000;

// kseg0/kseg1 drop the top three bits
localparam paddr_t PHYS_MASK = 32'h1FFF_FFFF;

endpackage

// ==== rtl/seg_map.sv ====
`timescale 1ns/1ps

module seg_map (
	input  logic            clk,
	input  logic            arst_n,
	input  logic            request,
	input  mem_pkg::vaddr_t vaddr,
	output logic            ready,
	output mem_pkg::paddr_t paddr,
	output logic            uncached,
	output logic            miss
);

logic in_kseg01;
logic in_kseg1;

assign in_kseg01 = (vaddr >= mem_pkg::KSEG0_BASE) && (vaddr < mem_pkg::KSEG2_BASE);
assign in_kseg1  = (vaddr >= mem_pkg::KSEG1_BASE) && (vaddr < mem_pkg::KSEG2_BASE);

always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n)
		ready <= 1'b0;
	else
		ready <= request;
end

// no tlb, so kuseg and kseg2/3 just miss
always_ff @(posedge clk) begin
	if (request) begin
		paddr    <= vaddr & mem_pkg::PHYS_MASK;
		uncached <= in_kseg1;
		miss     <= ~in_kseg01;
	end
end

endmodule
